// File: Makefile
SOURCES := $(shell cat mem_system.f)

all: run

obj_dir/Vmem_system_tb: mem_system.f $(SOURCES)
	verilator --binary --assert -Wno-fatal -f mem_system.f --top-module mem_system_tb -Mdir obj_dir

run: obj_dir/Vmem_system_tb
	obj_dir/Vmem_system_tb | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// File: design/cache_pkg.sv
/* Cache address layout, word typedefs and the request struct
   shared by both ways */
package cache_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Geometry
   ////////////////////////////////////////////////////////////////////////////

   // Sets per way
   localparam int num_sets = 256;
   // Words per line
   localparam int line_words = 4;

   ////////////////////////////////////////////////////////////////////////////
   // Address and data types
   ////////////////////////////////////////////////////////////////////////////

   // Byte address, tag 15:11, index 10:3, offset 2:0
   typedef logic [15:0] addr_t;
   typedef logic [15:0] data_t;
   typedef logic [4:0]  tag_t;
   typedef logic [7:0]  index_t;
   // Bit 0 must be zero for a word access
   typedef logic [2:0]  offset_t;

   // Request seen by both ways in the same cycle
   typedef struct packed {
      tag_t    tag;
      index_t  index;
      offset_t offset;
      data_t   data_in;
      // Compare mode, tag checked against the stored line
      logic    comp;
      logic    write;
      // Valid written by an access write
      logic    valid_in;
   } way_req_t;

endpackage

// File: design/cache_way.sv
/* One cache way: data, tag, valid and dirty storage per line
   with compare and access modes */
module cache_way (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                enable,
   input  cache_pkg::way_req_t req,
   output cache_pkg::tag_t     tag_out,
   output cache_pkg::data_t    data_out,
   output logic                hit,
   output logic                dirty,
   output logic                valid,
   output logic                err
);
   import cache_pkg::*;

   // Line storage
   data_t data_arr  [num_sets][line_words];
   tag_t  tag_arr   [num_sets];
   logic  valid_arr [num_sets];
   logic  dirty_arr [num_sets];

   logic [1:0] word_sel;
   logic       tag_match;
   logic       cmp_hit;
   logic       wr_en;
   logic       acc_wr;
   logic       data_we;

   ////////////////////////////////////////////////////////////////////////////
   // Lookup
   ////////////////////////////////////////////////////////////////////////////

   // Word within the line
   assign word_sel  = req.offset[2:1];
   assign tag_match = (tag_arr[req.index] == req.tag);
   // Stale tags behind a cleared valid never match
   assign cmp_hit   = req.comp & valid_arr[req.index] & tag_match;

   // Combinational read of the indexed line
   assign tag_out  = tag_arr[req.index];
   assign data_out = data_arr[req.index][word_sel];
   assign valid    = valid_arr[req.index];
   assign dirty    = dirty_arr[req.index];
   assign hit      = enable & cmp_hit;

   // Odd offset on an enabled access
   assign err = enable & req.offset[0];

   ////////////////////////////////////////////////////////////////////////////
   // Update
   ////////////////////////////////////////////////////////////////////////////

   assign wr_en  = enable & req.write;
   // Line fill or overwrite
   assign acc_wr = wr_en & ~req.comp;
   // Compare writes land only on a hit
   assign data_we = acc_wr | (wr_en & cmp_hit);

   // Valid and dirty per line
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < num_sets; i++) begin
            valid_arr[i] <= 1'b0;
            dirty_arr[i] <= 1'b0;
         end
      end else if (acc_wr) begin
         valid_arr[req.index] <= req.valid_in;
         // Freshly loaded line matches memory
         dirty_arr[req.index] <= 1'b0;
      end else if (wr_en && cmp_hit) begin
         dirty_arr[req.index] <= 1'b1;
      end
   end

   // Word and tag storage
   always_ff @(posedge clk) begin
      if (data_we) begin
         data_arr[req.index][word_sel] <= req.data_in;
      end
      if (acc_wr) begin
         tag_arr[req.index] <= req.tag;
      end
   end

   // Controller fills always mark the line valid
   a_fill_sets_valid: assert property (@(posedge clk) disable iff (!rst_n)
      acc_wr |-> req.valid_in);

endmodule

// File: design/four_bank_mem.sv
/* Four-bank word-interleaved main memory with a fixed
   read pipeline and per-bank busy tracking */
module four_bank_mem (
   input  logic              clk,
   input  logic              rst_n,
   input  mem_pkg::mem_req_t req,
   output cache_pkg::data_t  data_out,
   output logic              err
);
   import cache_pkg::*;
   import mem_pkg::*;

   typedef logic [$clog2(bank_busy_cycles)-1:0] busy_t;

   // Word array, cleared at start
   data_t mem_arr [mem_words] = '{default: '0};

   logic [$clog2(mem_words)-1:0] word_addr;
   logic [$clog2(num_banks)-1:0] bank_sel;
   logic                         req_any;

   // Read data pipeline
   data_t rd_pipe [rd_latency];
   logic  rd_vld  [rd_latency];

   // Cycles left per bank
   busy_t busy_cnt [num_banks];

   assign word_addr = req.addr[15:1];
   assign bank_sel  = req.addr[2:1];
   assign req_any   = req.rd | req.wr;

   // Conflicting strobes or a misaligned word
   assign err = (req.rd & req.wr) | (req_any & req.addr[0]);

   ////////////////////////////////////////////////////////////////////////////
   // Array access
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (req.wr && !req.rd) begin
         mem_arr[word_addr] <= req.data_in;
      end
   end

   // Data moves one stage per cycle
   always_ff @(posedge clk) begin
      rd_pipe[0] <= mem_arr[word_addr];
      for (int s = 1; s < rd_latency; s++) begin
         rd_pipe[s] <= rd_pipe[s-1];
      end
   end

   // Marks which stages carry a real read
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int s = 0; s < rd_latency; s++) begin
            rd_vld[s] <= 1'b0;
         end
      end else begin
         rd_vld[0] <= req.rd & ~req.wr;
         for (int s = 1; s < rd_latency; s++) begin
            rd_vld[s] <= rd_vld[s-1];
         end
      end
   end

   // Zero between reads
   assign data_out = rd_vld[rd_latency-1] ? rd_pipe[rd_latency-1] : '0;

   ////////////////////////////////////////////////////////////////////////////
   // Bank occupancy
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int b = 0; b < num_banks; b++) begin
            busy_cnt[b] <= '0;
         end
      end else begin
         for (int b = 0; b < num_banks; b++) begin
            if (req_any && bank_sel == b) begin
               busy_cnt[b] <= busy_t'(bank_busy_cycles - 1);
            end else if (busy_cnt[b] != '0) begin
               busy_cnt[b] <= busy_cnt[b] - 1'b1;
            end
         end
      end
   end

   // Controller sweeps banks in order so a busy bank is never hit
   a_bank_free: assert property (@(posedge clk) disable iff (!rst_n)
      req_any |-> busy_cnt[bank_sel] == '0);

endmodule

// File: design/mem_pkg.sv
/* Main memory geometry and timing, memory request struct
   and the controller state encoding */
package mem_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Memory geometry and timing
   ////////////////////////////////////////////////////////////////////////////

   // 64 KB of 16-bit words
   localparam int mem_words = 32768;
   // Word interleaved, bank from address bits 2:1
   localparam int num_banks = 4;
   // Cycles a bank stays occupied after a request
   localparam int bank_busy_cycles = 4;
   // Read strobe to data out
   localparam int rd_latency = 2;

   // One memory access per cycle
   typedef struct packed {
      cache_pkg::addr_t addr;
      cache_pkg::data_t data_in;
      logic             rd;
      logic             wr;
   } mem_req_t;

   ////////////////////////////////////////////////////////////////////////////
   // Miss controller states
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [3:0] {
      st_idle,
      // Read path
      st_rd_cmp,
      st_rd_wb,
      st_rd_fill,
      st_rd_ret,
      // Write path
      st_wr_cmp,
      st_wr_wb,
      st_wr_fill,
      st_wr_ret
   } ctrl_state_t;

endpackage

// File: design/mem_system.sv
/* Cached memory system top: request capture, miss FSM,
   victim and fill-way choice, two ways and main memory */
module mem_system (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             Rd,
   input  logic             Wr,
   input  cache_pkg::addr_t Addr,
   input  cache_pkg::data_t DataIn,
   output cache_pkg::data_t DataOut,
   output logic             Done,
   output logic             Stall,
   output logic             CacheHit,
   output logic             err
);
   import cache_pkg::*;
   import mem_pkg::*;

   ctrl_state_t state;
   ctrl_state_t next_state;

   // Request held for the whole transaction
   addr_t addr_q;
   data_t data_q;

   // Write-back and fill beats
   logic [2:0] beat_cnt;
   logic [1:0] fill_word;
   logic       beat_inc;
   logic       beat_clr;

   // Replacement state
   logic victim;
   logic flag0;
   logic flag1;

   // Way interface
   way_req_t way_req;
   logic     en0;
   logic     en1;
   tag_t     tag0;
   tag_t     tag1;
   data_t    wdata0;
   data_t    wdata1;
   logic     hit0;
   logic     hit1;
   logic     dirty0;
   logic     dirty1;
   logic     valid0;
   logic     valid1;
   logic     werr0;
   logic     werr1;

   // Memory interface
   mem_req_t mem_req;
   data_t    mem_rdata;
   logic     mem_err;

   logic  is_cmp;
   logic  any_hit;
   logic  sel_v0;
   logic  sel_v1;
   logic  sel_vic;
   logic  repl_way;
   logic  need_wb;
   tag_t  repl_tag;
   data_t repl_data;

   ////////////////////////////////////////////////////////////////////////////
   // Way selection
   ////////////////////////////////////////////////////////////////////////////

   assign is_cmp  = (state == st_rd_cmp) | (state == st_wr_cmp);
   assign any_hit = hit0 | hit1;

   // Live valids and the toggled victim in compare and the captured copies later
   assign sel_v0  = is_cmp ? valid0 : flag0;
   assign sel_v1  = is_cmp ? valid1 : flag1;
   assign sel_vic = is_cmp ? ~victim : victim;

   // Empty way first, else victim bit (1 picks way1)
   assign repl_way = sel_v0 & (~sel_v1 | sel_vic);

   // Line being replaced is valid and modified
   assign need_wb = repl_way ? (valid1 & dirty1) : (valid0 & dirty0);

   assign repl_tag  = repl_way ? tag1 : tag0;
   assign repl_data = repl_way ? wdata1 : wdata0;

   // Cache writes trail memory reads by two beats
   assign fill_word = beat_cnt[1:0] - 2'd2;

   assign err = werr0 | werr1 | mem_err;

   ////////////////////////////////////////////////////////////////////////////
   // Registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= st_idle;
      end else begin
         state <= next_state;
      end
   end

   // Capture while idle so later input changes are ignored
   always_ff @(posedge clk) begin
      if (state == st_idle) begin
         addr_q <= Addr;
         data_q <= DataIn;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         beat_cnt <= '0;
      end else if (beat_clr) begin
         beat_cnt <= '0;
      end else if (beat_inc) begin
         beat_cnt <= beat_cnt + 3'd1;
      end
   end

   // Victim flips on each compare and the valids are kept for the fill
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         victim <= 1'b0;
         flag0  <= 1'b0;
         flag1  <= 1'b0;
      end else if (is_cmp) begin
         victim <= ~victim;
         flag0  <= valid0;
         flag1  <= valid1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Miss FSM
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      next_state = state;
      Stall      = 1'b1;
      Done       = 1'b0;
      CacheHit   = 1'b0;
      DataOut    = '0;
      beat_inc   = 1'b0;
      beat_clr   = 1'b0;
      en0        = 1'b0;
      en1        = 1'b0;

      // Default way request from the captured address
      way_req.tag      = addr_q[15:11];
      way_req.index    = addr_q[10:3];
      way_req.offset   = addr_q[2:0];
      way_req.data_in  = data_q;
      way_req.comp     = 1'b0;
      way_req.write    = 1'b0;
      way_req.valid_in = 1'b0;

      mem_req.addr    = '0;
      mem_req.data_in = '0;
      mem_req.rd      = 1'b0;
      mem_req.wr      = 1'b0;

      case (state)
         st_idle: begin
            Stall    = 1'b0;
            beat_clr = 1'b1;
            // Reads win if both strobes come together
            if (Rd) begin
               next_state = st_rd_cmp;
            end else if (Wr) begin
               next_state = st_wr_cmp;
            end
         end

         st_rd_cmp, st_wr_cmp: begin
            en0          = 1'b1;
            en1          = 1'b1;
            way_req.comp = 1'b1;
            // Compare write updates the matching way only
            way_req.write = (state == st_wr_cmp);
            Done          = any_hit;
            CacheHit      = any_hit;
            if (state == st_rd_cmp && any_hit) begin
               DataOut = hit1 ? wdata1 : wdata0;
            end
            if (any_hit) begin
               next_state = st_idle;
            end else if (need_wb) begin
               next_state = (state == st_rd_cmp) ? st_rd_wb : st_wr_wb;
            end else begin
               next_state = (state == st_rd_cmp) ? st_rd_fill : st_wr_fill;
            end
         end

         // Four words of the old line back to memory
         st_rd_wb, st_wr_wb: begin
            en0             = ~repl_way;
            en1             = repl_way;
            way_req.offset  = {beat_cnt[1:0], 1'b0};
            mem_req.addr    = {repl_tag, addr_q[10:3], beat_cnt[1:0], 1'b0};
            mem_req.data_in = repl_data;
            mem_req.wr      = 1'b1;
            if (beat_cnt == 3'd3) begin
               beat_clr   = 1'b1;
               next_state = (state == st_rd_wb) ? st_rd_fill : st_wr_fill;
            end else begin
               beat_inc = 1'b1;
            end
         end

         // Reads on beats 0 to 3 and cache writes on beats 2 to 5
         st_rd_fill, st_wr_fill: begin
            beat_inc         = 1'b1;
            en0              = ~repl_way;
            en1              = repl_way;
            mem_req.addr     = {addr_q[15:3], beat_cnt[1:0], 1'b0};
            mem_req.rd       = ~beat_cnt[2];
            way_req.offset   = {fill_word, 1'b0};
            way_req.data_in  = mem_rdata;
            way_req.write    = (beat_cnt >= 3'd2);
            way_req.valid_in = 1'b1;
            if (beat_cnt == 3'd5) begin
               next_state = (state == st_rd_fill) ? st_rd_ret : st_wr_ret;
            end
         end

         // Access read of the new line
         st_rd_ret: begin
            en0        = ~repl_way;
            en1        = repl_way;
            DataOut    = repl_data;
            Done       = 1'b1;
            next_state = st_idle;
         end

         // Compare write so the line turns dirty
         st_wr_ret: begin
            en0           = ~repl_way;
            en1           = repl_way;
            way_req.comp  = 1'b1;
            way_req.write = 1'b1;
            Done          = 1'b1;
            next_state    = st_idle;
         end

         default: begin
            next_state = st_idle;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Instances
   ////////////////////////////////////////////////////////////////////////////

   cache_way way0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .enable   (en0),
      .req      (way_req),
      .tag_out  (tag0),
      .data_out (wdata0),
      .hit      (hit0),
      .dirty    (dirty0),
      .valid    (valid0),
      .err      (werr0)
   );

   cache_way way1 (
      .clk      (clk),
      .rst_n    (rst_n),
      .enable   (en1),
      .req      (way_req),
      .tag_out  (tag1),
      .data_out (wdata1),
      .hit      (hit1),
      .dirty    (dirty1),
      .valid    (valid1),
      .err      (werr1)
   );

   four_bank_mem mem (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (mem_req),
      .data_out (mem_rdata),
      .err      (mem_err)
   );

   // Done ends a transaction and the FSM is idle right after
   a_done_then_idle: assert property (@(posedge clk) disable iff (!rst_n)
      Done |-> state != st_idle ##1 state == st_idle);

   // Fill lands in exactly one way
   a_fill_one_way: assert property (@(posedge clk) disable iff (!rst_n)
      (way_req.write && !way_req.comp) |-> !(en0 && en1));

endmodule

// File: mem_system.f
design/cache_pkg.sv
design/mem_pkg.sv
design/cache_way.sv
design/four_bank_mem.sv
design/mem_system.sv
tb/mem_system_tb.sv

// File: tb/mem_system_tb.sv
/* Testbench for the cached memory system: clock, reset, xorshift stimulus,
   reference model of tags and memory contents, compare tasks, watchdog */
module mem_system_tb;
   import cache_pkg::*;
   import mem_pkg::*;

   typedef int unsigned cycles_t;

   localparam int clk_period = 100;
   localparam int reset_cycles = 4;
   localparam int num_ops = 400;
   // Each op may add a read-back request
   localparam int max_reqs = 2 * num_ops;
   localparam int cycles_per_req = 20;
   // Expected request latencies counted from the accepting edge
   localparam cycles_t hit_cycles = 1;
   localparam cycles_t clean_miss_cycles = 8;
   localparam cycles_t dirty_miss_cycles = 12;

   logic  clk;
   logic  rst_n;
   logic  Rd;
   logic  Wr;
   addr_t Addr;
   data_t DataIn;
   data_t DataOut;
   logic  Done;
   logic  Stall;
   logic  CacheHit;
   logic  err;

   // Reference model, two ways of tag state plus last written data
   tag_t  m_tag   [2][num_sets];
   logic  m_valid [2][num_sets];
   logic  m_dirty [2][num_sets];
   logic  m_victim;
   data_t shadow_mem [mem_words];

   logic [31:0] rng;

   mem_system dut (
      .clk      (clk),
      .rst_n    (rst_n),
      .Rd       (Rd),
      .Wr       (Wr),
      .Addr     (Addr),
      .DataIn   (DataIn),
      .DataOut  (DataOut),
      .Done     (Done),
      .Stall    (Stall),
      .CacheHit (CacheHit),
      .err      (err)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Failure reporting and compare tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_data(input string name, input data_t got, input data_t exp);
      if (got !== exp) begin
         stop_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_cycles(input string name, input cycles_t got, input cycles_t exp);
      if (got != exp) begin
         stop_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Four tags over four sets, so sets overflow and lines get evicted
   function automatic addr_t pick_addr(input logic [31:0] r);
      tag_t    tg;
      index_t  idx;
      offset_t off;
      tg  = {r[1:0], 3'b101};
      idx = {r[3:2], 6'h15};
      // Roughly one in sixteen misaligned
      off = {r[5:4], (r[11:8] == 4'h0)};
      return {tg, idx, off};
   endfunction

   // Hit or miss, latency, then the line and victim updates
   task automatic predict_access(input logic is_wr, input addr_t a,
                                 output logic hit, output cycles_t lat);
      index_t idx;
      tag_t   tg;
      logic   hit_way;
      logic   repl;
      idx     = a[10:3];
      tg      = a[15:11];
      hit     = 1'b0;
      hit_way = 1'b0;
      repl    = 1'b0;
      for (int i = 0; i < 2; i++) begin
         if (m_valid[i][idx] && m_tag[i][idx] == tg) begin
            hit     = 1'b1;
            hit_way = i[0];
         end
      end
      if (hit) begin
         lat = hit_cycles;
         if (is_wr) begin
            m_dirty[hit_way][idx] = 1'b1;
         end
      end else begin
         // Empty way first, else the way the victim bit does not point at
         if (!m_valid[0][idx]) begin
            repl = 1'b0;
         end else if (!m_valid[1][idx]) begin
            repl = 1'b1;
         end else begin
            repl = ~m_victim;
         end
         if (m_valid[repl][idx] && m_dirty[repl][idx]) begin
            lat = dirty_miss_cycles;
         end else begin
            lat = clean_miss_cycles;
         end
         m_tag[repl][idx]   = tg;
         m_valid[repl][idx] = 1'b1;
         m_dirty[repl][idx] = is_wr;
      end
      // Toggles on every compare, hit or miss
      m_victim = ~m_victim;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // One processor request
   ////////////////////////////////////////////////////////////////////////////

   task automatic run_request(input logic is_wr, input addr_t a, input data_t d);
      logic    exp_hit;
      cycles_t exp_cycles;
      cycles_t cycles;
      logic    done_seen;
      data_t   exp_data;
      logic    odd;
      odd = a[0];
      predict_access(is_wr, a, exp_hit, exp_cycles);
      exp_data = shadow_mem[a[15:1]];
      if (is_wr) begin
         shadow_mem[a[15:1]] = d;
      end

      @(posedge clk);
      Rd     <= ~is_wr;
      Wr     <= is_wr;
      Addr   <= a;
      DataIn <= d;
      @(negedge clk);
      check_bit("Stall", Stall, 1'b0);
      // Accepting edge
      @(posedge clk);
      Rd <= 1'b0;
      Wr <= 1'b0;

      cycles    = 0;
      done_seen = 1'b0;
      while (!done_seen) begin
         @(negedge clk);
         cycles++;
         check_bit("Stall", Stall, 1'b1);
         // err checked in the compare cycle for misaligned requests
         if (odd && cycles == 1) begin
            check_bit("err", err, 1'b1);
         end else if (!odd) begin
            check_bit("err", err, 1'b0);
         end
         if (Done) begin
            done_seen = 1'b1;
         end else if (cycles > cycles_per_req) begin
            stop_run("Done never arrived for the current request");
         end else begin
            check_bit("CacheHit", CacheHit, 1'b0);
         end
      end
      check_cycles("latency", cycles, exp_cycles);
      check_bit("CacheHit", CacheHit, exp_hit);
      if (!is_wr) begin
         check_data("DataOut", DataOut, exp_data);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      addr_t a;
      logic  is_wr;
      rst_n  <= 1'b0;
      Rd     <= 1'b0;
      Wr     <= 1'b0;
      Addr   <= '0;
      DataIn <= '0;
      rng = 32'hf8e;
      m_victim = 1'b0;
      for (int s = 0; s < num_sets; s++) begin
         for (int w = 0; w < 2; w++) begin
            m_tag[w][s]   = '0;
            m_valid[w][s] = 1'b0;
            m_dirty[w][s] = 1'b0;
         end
      end
      // Main memory starts at zero
      for (int i = 0; i < mem_words; i++) begin
         shadow_mem[i] = '0;
      end

      repeat (reset_cycles) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_bit("Stall", Stall, 1'b0);
      check_bit("Done", Done, 1'b0);
      check_bit("CacheHit", CacheHit, 1'b0);

      for (int n = 0; n < num_ops; n++) begin
         rng   = xorshift32(rng);
         a     = pick_addr(rng);
         rng   = xorshift32(rng);
         is_wr = rng[0];
         run_request(is_wr, a, rng[31:16]);
         // Read back right after a write, must hit
         if (is_wr) begin
            run_request(1'b0, a, '0);
         end
      end

      $display("Verification passed");
      $finish;
   end

   // Watchdog over the whole run
   initial begin
      #((reset_cycles + 4 + cycles_per_req * max_reqs) * clk_period);
      stop_run("Timeout, the request sequence did not finish in time");
   end

endmodule
